// ==== sqrt_accel_params.svh ====
`ifndef SQRT_ACCEL_PARAMS_SVH
`define SQRT_ACCEL_PARAMS_SVH

// Operand and result width in bits.
`define SQRT_WIDTH 32

// Fractional bits of the fixed-point format, giving Q16.16.
`define SQRT_FRAC_WIDTH 16

// Host register address width.
`define SQRT_ADDR_WIDTH 3

`endif

// ==== sqrt_pkg.sv ====
`include "sqrt_accel_params.svh"

package sqrt_pkg;

    // Host register map.
    typedef enum logic [`SQRT_ADDR_WIDTH-1:0] {
        REG_OPERAND = 0,
        REG_CTRL    = 1,
        REG_STATUS  = 2,
        REG_RESULT  = 3
    } sqrt_reg_e;

    // Result format, picked per operation.
    typedef enum logic {
        FMT_INT   = 1'b0,
        FMT_FIXED = 1'b1
    } sqrt_fmt_e;

    // Core sequencer states.
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1
    } sqrt_state_e;

endpackage

// ==== fp_sqrt.sv ====
`timescale 1ns/1ps
`include "sqrt_accel_params.svh"

module fp_sqrt #(
    parameter int WIDTH      = `SQRT_WIDTH,
    parameter int FRAC_WIDTH = `SQRT_FRAC_WIDTH
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                go,
    input  logic [WIDTH-1:0]    operand,
    input  sqrt_pkg::sqrt_fmt_e fmt,
    output logic [WIDTH-1:0]    result,
    output logic                busy,
    output logic                done
);
    import sqrt_pkg::*;

    // One result bit per iteration, two radicand bits consumed each time.
    localparam int ITER_INT = WIDTH / 2;
    localparam int ITER_FIX = (WIDTH + FRAC_WIDTH) / 2;
    localparam int CNT_W    = $clog2(ITER_FIX + 1);
    localparam int REM_W    = WIDTH + 2;

    localparam logic [CNT_W-1:0] LAST_INT = CNT_W'(ITER_INT - 1);
    localparam logic [CNT_W-1:0] LAST_FIX = CNT_W'(ITER_FIX - 1);

    sqrt_state_e      state;
    sqrt_fmt_e        fmt_q;     // Format of the running operation.
    logic [CNT_W-1:0] cnt;
    logic             start;
    logic             last;

    logic [WIDTH-1:0] x_q;       // Radicand bits still to be consumed, MSBs first.
    logic [WIDTH-1:0] root_q;
    logic [WIDTH-1:0] root_next;
    logic [REM_W-1:0] rem_q;
    logic [REM_W-1:0] rem_next;
    logic [REM_W+1:0] rem_ext;
    logic [REM_W+2:0] diff;

    assign busy  = (state == ST_RUN);
    assign start = go && (state == ST_IDLE); // Go is ignored while running.
    assign last  = busy && (cnt == ((fmt_q == FMT_FIXED) ? LAST_FIX : LAST_INT));

    // Trial subtraction of the partial root with 01 appended.
    always_comb begin
        rem_ext = {rem_q, x_q[WIDTH-1 -: 2]};
        diff    = {1'b0, rem_ext} - {3'b000, root_q, 2'b01};
        if (diff[REM_W+2]) begin
            rem_next  = rem_ext[REM_W-1:0]; // Negative, keep the remainder.
            root_next = {root_q[WIDTH-2:0], 1'b0};
        end else begin
            rem_next  = diff[REM_W-1:0];
            root_next = {root_q[WIDTH-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= ST_IDLE;
            fmt_q  <= FMT_INT;
            cnt    <= '0;
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (go) begin
                        state <= ST_RUN;
                        fmt_q <= fmt;
                        cnt   <= '0;
                    end
                end
                ST_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (last) begin
                        state  <= ST_IDLE;
                        done   <= 1'b1;
                        result <= root_next;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // In fixed point the later iterations see zero pairs shifted in from the right,
    // which scales the radicand by 2**FRAC_WIDTH.
    always_ff @(posedge clk) begin
        if (start) begin
            x_q    <= operand;
            root_q <= '0;
            rem_q  <= '0;
        end else if (busy) begin
            x_q    <= x_q << 2;
            root_q <= root_next;
            rem_q  <= rem_next;
        end
    end

endmodule

// ==== sqrt_regs.sv ====
`timescale 1ns/1ps
`include "sqrt_accel_params.svh"

module sqrt_regs (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        wr_en,
    input  logic [`SQRT_ADDR_WIDTH-1:0] wr_addr,
    input  logic [`SQRT_WIDTH-1:0]      wr_data,
    input  logic                        rd_en,
    input  logic [`SQRT_ADDR_WIDTH-1:0] rd_addr,
    input  logic                        busy,
    input  logic                        done,
    input  logic [`SQRT_WIDTH-1:0]      result,
    output logic [`SQRT_WIDTH-1:0]      rd_data,
    output logic                        irq,
    output logic                        go,
    output logic [`SQRT_WIDTH-1:0]      operand,
    output sqrt_pkg::sqrt_fmt_e         fmt
);
    import sqrt_pkg::*;

    // CTRL bits.
    localparam int CTRL_START  = 0;
    localparam int CTRL_FMT    = 1;
    localparam int CTRL_IRQ_EN = 2;

    // STATUS bits.
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;

    logic                   irq_en;
    logic                   done_flag;   // Sticky until the result is read.
    logic [`SQRT_WIDTH-1:0] result_q;
    logic [`SQRT_WIDTH-1:0] ctrl_word;
    logic [`SQRT_WIDTH-1:0] status_word;
    logic                   wr_operand;
    logic                   wr_ctrl;
    logic                   rd_result;

    assign wr_operand = wr_en && (sqrt_reg_e'(wr_addr) == REG_OPERAND);
    assign wr_ctrl    = wr_en && (sqrt_reg_e'(wr_addr) == REG_CTRL);
    assign rd_result  = rd_en && (sqrt_reg_e'(rd_addr) == REG_RESULT);

    assign irq = done_flag && irq_en;

    // Start reads back as zero.
    always_comb begin
        ctrl_word              = '0;
        ctrl_word[CTRL_FMT]    = fmt;
        ctrl_word[CTRL_IRQ_EN] = irq_en;
    end

    always_comb begin
        status_word            = '0;
        status_word[STAT_BUSY] = busy;
        status_word[STAT_DONE] = done_flag;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            operand <= '0;
        end else if (wr_operand) begin
            operand <= wr_data;
        end
    end

    // Format and irq_en are levels, start becomes a one-cycle go.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fmt    <= FMT_INT;
            irq_en <= 1'b0;
            go     <= 1'b0;
        end else begin
            go <= 1'b0;
            if (wr_ctrl) begin
                fmt    <= sqrt_fmt_e'(wr_data[CTRL_FMT]);
                irq_en <= wr_data[CTRL_IRQ_EN];
                go     <= wr_data[CTRL_START];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_q  <= '0;
            done_flag <= 1'b0;
        end else begin
            if (done) begin
                result_q  <= result;
                done_flag <= 1'b1; // A fresh result wins over a read in the same cycle.
            end else if (rd_result) begin
                done_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            case (sqrt_reg_e'(rd_addr))
                REG_OPERAND: rd_data <= operand;
                REG_CTRL:    rd_data <= ctrl_word;
                REG_STATUS:  rd_data <= status_word;
                REG_RESULT:  rd_data <= result_q;
                default:     rd_data <= '0;
            endcase
        end
    end

endmodule

// ==== sqrt_accel.sv ====
`timescale 1ns/1ps
`include "sqrt_accel_params.svh"

module sqrt_accel (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        wr_en,
    input  logic [`SQRT_ADDR_WIDTH-1:0] wr_addr,
    input  logic [`SQRT_WIDTH-1:0]      wr_data,
    input  logic                        rd_en,
    input  logic [`SQRT_ADDR_WIDTH-1:0] rd_addr,
    output logic [`SQRT_WIDTH-1:0]      rd_data,
    output logic                        irq
);
    import sqrt_pkg::*;

    logic                   go;
    logic [`SQRT_WIDTH-1:0] operand;
    sqrt_fmt_e              fmt;
    logic                   busy;
    logic                   done;
    logic [`SQRT_WIDTH-1:0] result;

    sqrt_regs u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .busy    (busy),
        .done    (done),
        .result  (result),
        .rd_data (rd_data),
        .irq     (irq),
        .go      (go),
        .operand (operand),
        .fmt     (fmt)
    );

    fp_sqrt #(
        .WIDTH      (`SQRT_WIDTH),
        .FRAC_WIDTH (`SQRT_FRAC_WIDTH)
    ) u_core (
        .clk     (clk),
        .arst_n  (arst_n),
        .go      (go),
        .operand (operand),
        .fmt     (fmt),
        .result  (result),
        .busy    (busy),
        .done    (done)
    );

endmodule

// ==== tb_sqrt_accel.sv ====
`timescale 1ns/1ps
`include "sqrt_accel_params.svh"

module tb_sqrt_accel;
    import sqrt_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int POLL_LIMIT   = 100;   // STATUS reads before giving up.
    localparam int N_RANDOM     = 32;

    // CTRL and STATUS bit positions.
    localparam int CTRL_START  = 0;
    localparam int CTRL_FMT    = 1;
    localparam int CTRL_IRQ_EN = 2;
    localparam int STAT_BUSY   = 0;
    localparam int STAT_DONE   = 1;

    logic                        clk;
    logic                        arst_n;
    logic                        wr_en;
    logic [`SQRT_ADDR_WIDTH-1:0] wr_addr;
    logic [`SQRT_WIDTH-1:0]      wr_data;
    logic                        rd_en;
    logic [`SQRT_ADDR_WIDTH-1:0] rd_addr;
    logic [`SQRT_WIDTH-1:0]      rd_data;
    logic                        irq;

    int n_pass;
    int n_fail;

    sqrt_accel UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .irq     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [`SQRT_WIDTH-1:0] expected,
                               input logic [`SQRT_WIDTH-1:0] actual);
        if (actual === expected) begin
            n_pass++;
            $display("PASS %s", name);
        end else begin
            n_fail++;
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
        end
    endtask

    // All host tasks start and end 1 ns after a rising edge.
    task automatic write_reg(input sqrt_reg_e addr, input logic [`SQRT_WIDTH-1:0] data);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    task automatic read_reg(input sqrt_reg_e addr, output logic [`SQRT_WIDTH-1:0] data);
        rd_en   = 1'b1;
        rd_addr = addr;
        @(posedge clk);
        #1;
        rd_en = 1'b0;
        data  = rd_data; // Registered at the edge just passed.
    endtask

    task automatic poll_status(input int bit_idx, input string name, output logic ok);
        logic [`SQRT_WIDTH-1:0] status;
        int polls;
        ok    = 1'b0;
        polls = 0;
        while (!ok && polls < POLL_LIMIT) begin
            read_reg(REG_STATUS, status);
            ok = status[bit_idx];
            polls++;
        end
        if (!ok) begin
            n_fail++;
            $display("Timeout in %s: STATUS bit %0d was still clear after %0d reads",
                     name, bit_idx, POLL_LIMIT);
        end
    endtask

    task automatic start_op(input sqrt_fmt_e fmt, input logic [`SQRT_WIDTH-1:0] operand,
                            input logic irq_en);
        logic [`SQRT_WIDTH-1:0] ctrl;
        ctrl              = '0;
        ctrl[CTRL_START]  = 1'b1;
        ctrl[CTRL_FMT]    = fmt;
        ctrl[CTRL_IRQ_EN] = irq_en;
        write_reg(REG_OPERAND, operand);
        write_reg(REG_CTRL, ctrl);
    endtask

    task automatic run_op(input string name, input sqrt_fmt_e fmt,
                          input logic [`SQRT_WIDTH-1:0] operand,
                          output logic [`SQRT_WIDTH-1:0] result, output logic ok);
        start_op(fmt, operand, 1'b0);
        poll_status(STAT_DONE, name, ok);
        result = 'x;
        if (ok) begin
            read_reg(REG_RESULT, result);
        end
    endtask

    // Largest root whose square stays within x, found one bit at a time.
    function automatic logic [`SQRT_WIDTH-1:0] int_sqrt(input logic [`SQRT_WIDTH-1:0] x);
        logic [`SQRT_WIDTH-1:0] root;
        logic [`SQRT_WIDTH-1:0] trial;
        logic [2*`SQRT_WIDTH-1:0] sq;
        root = '0;
        for (int b = `SQRT_WIDTH / 2 - 1; b >= 0; b--) begin
            trial = root | (`SQRT_WIDTH'(1) << b);
            sq    = (2*`SQRT_WIDTH)'(trial) * (2*`SQRT_WIDTH)'(trial);
            if (sq <= (2*`SQRT_WIDTH)'(x)) begin
                root = trial;
            end
        end
        return root;
    endfunction

    initial begin
        logic [`SQRT_WIDTH-1:0] data;
        logic [`SQRT_WIDTH-1:0] result;
        logic [`SQRT_WIDTH-1:0] op;
        logic [`SQRT_WIDTH-1:0] v_fmt;
        logic [`SQRT_WIDTH-1:0] v_op;
        logic [`SQRT_WIDTH-1:0] v_exp;
        logic [8*160-1:0]       line;
        logic                   ok;
        string                  name;
        int                     fd;
        int                     code;
        int                     idx;

        n_pass  = 0;
        n_fail  = 0;
        arst_n  = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_en   = 1'b0;
        rd_addr = '0;
        void'($urandom(32'h839968de));

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;

        // Reset values.
        for (int i = 0; i < 4; i++) begin
            read_reg(sqrt_reg_e'(i), data);
            check_value($sformatf("reset read of register %0d", i), '0, data);
        end
        check_value("reset irq", '0, irq);

        // Vectors with expected results from the stim file.
        fd = $fopen("sqrt_stim.txt", "r");
        if (fd == 0) begin
            n_fail++;
            $display("Could not open sqrt_stim.txt for reading");
        end else begin
            idx = 0;
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && $sscanf(line, "%h %h %h", v_fmt, v_op, v_exp) == 3) begin
                    name = $sformatf("stim %0d fmt %0d operand 0x%08h", idx, v_fmt[0], v_op);
                    run_op(name, sqrt_fmt_e'(v_fmt[0]), v_op, result, ok);
                    if (ok) begin
                        check_value(name, v_exp, result);
                    end
                    idx++;
                end
            end
            $fclose(fd);
            if (idx == 0) begin
                n_fail++;
                $display("No vectors were found in sqrt_stim.txt");
            end
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            op   = $urandom;
            name = $sformatf("random %0d operand 0x%08h", i, op);
            run_op(name, FMT_INT, op, result, ok);
            if (ok) begin
                check_value(name, int_sqrt(op), result);
            end
        end

        // A start written while busy must be dropped.
        start_op(FMT_INT, 32'h12345678, 1'b0);
        poll_status(STAT_BUSY, "overlap busy wait", ok);
        if (ok) begin
            start_op(FMT_INT, 32'h00000400, 1'b0);
        end
        poll_status(STAT_DONE, "overlap done wait", ok);
        read_reg(REG_STATUS, data);
        check_value("overlap status after done", `SQRT_WIDTH'(1 << STAT_DONE), data);
        read_reg(REG_RESULT, result);
        check_value("overlap result", int_sqrt(32'h12345678), result);

        // Interrupt enabled.
        start_op(FMT_INT, 32'h00000051, 1'b1);
        poll_status(STAT_DONE, "irq enabled done wait", ok);
        check_value("irq high after done", 1, irq);
        read_reg(REG_RESULT, result);
        check_value("irq enabled result", 9, result);   // sqrt(81).
        check_value("irq low after result read", 0, irq);
        read_reg(REG_STATUS, data);
        check_value("done cleared by result read", 0, data[STAT_DONE]);

        // Interrupt disabled.
        start_op(FMT_INT, 32'h00000090, 1'b0);
        poll_status(STAT_DONE, "irq disabled done wait", ok);
        check_value("irq low while disabled", 0, irq);
        read_reg(REG_STATUS, data);
        check_value("done set with irq disabled", 1, data[STAT_DONE]);
        read_reg(REG_RESULT, result);
        check_value("irq disabled result", 12, result); // sqrt(144).

        $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sqrt_accel.f ====
+incdir+.
sqrt_pkg.sv
fp_sqrt.sv
sqrt_regs.sv
sqrt_accel.sv
tb_sqrt_accel.sv

// ==== sqrt_stim.txt ====
# fmt (0 integer, 1 Q16.16)  operand  expected result
# all columns hexadecimal
0 00000000 00000000
0 00000001 00000001
0 00000002 00000001
0 00000003 00000001
0 00000004 00000002
0 0000000F 00000003
0 00000010 00000004
0 00000063 00000009
0 00000064 0000000A
0 00003FFF 0000007F
0 00004000 00000080
0 000F423F 000003E7
0 000F4240 000003E8
0 12345678 00004444
0 3FFFFFFF 00007FFF
0 40000000 00008000
0 FFFE0000 0000FFFE
0 FFFE0001 0000FFFF
0 FFFFFFFF 0000FFFF
1 00000000 00000000
1 00000001 00000100
1 00004000 00008000
1 00008000 0000B504
1 00010000 00010000
1 00020000 00016A09
1 00030000 0001BB67
1 00040000 00020000
1 00090000 00030000
1 00640000 000A0000
1 01000000 00100000
1 FFFFFFFF 00FFFFFF
